// ==== src/zx_mem_pkg.sv ====
package zx_mem_pkg;

	////////////////////////////////////////
	// z80 bus
	////////////////////////////////////////

	localparam int ZA_W = 16;
	localparam int ZD_W = 8;

	////////////////////////////////////////
	// memory words and paging
	////////////////////////////////////////

	localparam int WA_W = 21;
	localparam int WD_W = 16;
	localparam int PAGE_W = 8;
	localparam int WIN_N = 4;
	// 16 KB window holds 8K words
	localparam int WIN_OFS_W = 13;

	// store keeps 64K words, so pages 0..7 are distinct
	localparam int MEM_AW = 16;

	// store pipeline and flow control
	localparam int MEM_LAT = 3;
	localparam int MEM_CREDITS = 2;
	localparam int CRED_W = $clog2(MEM_CREDITS + 1);

	// screen burst
	localparam int VID_WORDS = 16;
	localparam int VCNT_W = $clog2(VID_WORDS);

	typedef logic [PAGE_W-1:0] page_t;
	typedef logic [WA_W-1:0] waddr_t;
	typedef logic [WD_W-1:0] word_t;

	// response routing tag
	typedef enum logic
	{
		TAG_VID = 1'b0,
		TAG_CPU = 1'b1
	} tag_t;

	localparam page_t SCR_PAGE0 = 8'd5;
	localparam page_t SCR_PAGE1 = 8'd7;

	// window i comes up mapped to page i
	localparam page_t [WIN_N-1:0] RESET_PAGE = {8'd3, 8'd2, 8'd1, 8'd0};
	// window 0 stands in for rom
	localparam logic [WIN_N-1:0] RESET_PROT = 4'b0001;

endpackage

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;

	// request fields held until gnt
	logic req;
	zx_mem_pkg::waddr_t addr;
	logic rnw;
	logic [1:0] bsel;
	zx_mem_pkg::word_t wdata;

	// accept and read response
	logic gnt;
	logic rvalid;
	zx_mem_pkg::word_t rdata;

	modport requester
	(
		output req, addr, rnw, bsel, wdata,
		input  gnt, rvalid, rdata
	);

	modport arbiter
	(
		input  req, addr, rnw, bsel, wdata,
		output gnt, rvalid, rdata
	);

endinterface

// ==== src/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;

	// request side spends one credit per valid
	logic valid;
	zx_mem_pkg::waddr_t addr;
	logic rnw;
	logic [1:0] bsel;
	zx_mem_pkg::word_t wdata;
	zx_mem_pkg::tag_t tag;

	// response side
	logic rvalid;
	zx_mem_pkg::word_t rdata;
	zx_mem_pkg::tag_t rtag;
	logic credit;

	modport arbiter
	(
		output valid, addr, rnw, bsel, wdata, tag,
		input  rvalid, rdata, rtag, credit
	);

	modport store
	(
		input  valid, addr, rnw, bsel, wdata, tag,
		output rvalid, rdata, rtag, credit
	);

endinterface

// ==== src/window_pager.sv ====
`timescale 1ns/1ps

module window_pager
(
	input  logic fclk,
	input  logic rst_n,

	// page register write
	input  logic page_wr,
	input  logic [1:0] page_win,
	input  zx_mem_pkg::page_t page_val,
	input  logic page_prot,

	// translation
	input  logic [zx_mem_pkg::ZA_W-1:0] za,
	output zx_mem_pkg::waddr_t waddr,
	output logic [1:0] bsel,
	output logic prot
);
	import zx_mem_pkg::*;

	page_t [WIN_N-1:0] page_q;
	logic [WIN_N-1:0] prot_q;
	logic [1:0] win;

	////////////////////////////////////////
	// page and protect registers
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			page_q <= RESET_PAGE;
			prot_q <= RESET_PROT;
		end
		else if (page_wr)
		begin
			page_q[page_win] <= page_val;
			prot_q[page_win] <= page_prot;
		end
	end

	////////////////////////////////////////
	// address translation
	////////////////////////////////////////

	// top two bits pick the window
	assign win = za[ZA_W-1:ZA_W-2];

	// page number above the word offset
	assign waddr = {page_q[win], za[WIN_OFS_W:1]};

	// even byte sits in the low half of the word
	assign bsel = za[0] ? 2'b10 : 2'b01;

	assign prot = prot_q[win];

endmodule

// ==== src/z80_mem_port.sv ====
`timescale 1ns/1ps

module z80_mem_port
(
	input  logic fclk,
	input  logic rst_n,

	// z80 side
	input  logic cpu_req,
	input  logic cpu_rnw,
	input  logic [zx_mem_pkg::ZA_W-1:0] cpu_a,
	input  logic [zx_mem_pkg::ZD_W-1:0] cpu_dout,
	output logic [zx_mem_pkg::ZD_W-1:0] cpu_din,
	output logic cpu_busy,
	output logic cpu_done,

	// pager
	output logic [zx_mem_pkg::ZA_W-1:0] pg_a,
	input  zx_mem_pkg::waddr_t waddr,
	input  logic [1:0] bsel,
	input  logic prot,

	mem_req_if.requester mem
);
	import zx_mem_pkg::*;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_REQ,
		ST_RD
	} state_t;

	state_t state;
	logic rnw_q;
	logic [ZA_W-1:0] a_q;
	logic [ZD_W-1:0] dout_q;
	logic blocked;

	// latched access
	always_ff @(posedge fclk)
	begin
		if (state == ST_IDLE && cpu_req)
		begin
			rnw_q  <= cpu_rnw;
			a_q    <= cpu_a;
			dout_q <= cpu_dout;
		end
	end

	assign pg_a = a_q;

	// writes into a protected window never reach memory
	assign blocked = !rnw_q && prot;

	////////////////////////////////////////
	// access FSM
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (cpu_req)
						state <= ST_REQ;
				ST_REQ:
					if (blocked)
						state <= ST_IDLE;
					else if (mem.gnt)
						state <= rnw_q ? ST_RD : ST_IDLE;
				ST_RD:
					if (mem.rvalid)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// request fields follow the pager
	assign mem.req   = (state == ST_REQ) && !blocked;
	assign mem.addr  = waddr;
	assign mem.rnw   = rnw_q;
	assign mem.bsel  = bsel;
	assign mem.wdata = {dout_q, dout_q};

	assign cpu_busy = (state != ST_IDLE);

	// write done at grant, read done with its data
	assign cpu_done = (state == ST_REQ && blocked) ||
	                  (state == ST_REQ && !rnw_q && mem.gnt) ||
	                  (state == ST_RD && mem.rvalid);

	assign cpu_din = a_q[0] ? mem.rdata[15:8] : mem.rdata[7:0];

endmodule

// ==== src/screen_fetch.sv ====
`timescale 1ns/1ps

module screen_fetch
(
	input  logic fclk,
	input  logic rst_n,

	input  logic frame_start,
	input  logic scr_sel,

	output zx_mem_pkg::word_t vid_data,
	output logic vid_strobe,
	output logic vid_last,

	mem_req_if.requester mem
);
	import zx_mem_pkg::*;

	logic busy;
	logic req_q;
	logic [VCNT_W-1:0] cnt;
	page_t page_q;

	// screen page latched at burst start
	always_ff @(posedge fclk)
	begin
		if (frame_start && !busy)
			page_q <= scr_sel ? SCR_PAGE1 : SCR_PAGE0;
	end

	////////////////////////////////////////
	// burst control
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			busy       <= 1'b0;
			req_q      <= 1'b0;
			cnt        <= '0;
			vid_strobe <= 1'b0;
			vid_last   <= 1'b0;
		end
		else
		begin
			vid_strobe <= 1'b0;
			vid_last   <= 1'b0;

			if (!busy)
			begin
				if (frame_start)
				begin
					busy  <= 1'b1;
					req_q <= 1'b1;
					cnt   <= '0;
				end
			end
			else
			begin
				if (mem.gnt)
					req_q <= 1'b0;

				// one word back, show it and go for the next
				if (mem.rvalid)
				begin
					vid_strobe <= 1'b1;
					if (cnt == VCNT_W'(VID_WORDS - 1))
					begin
						vid_last <= 1'b1;
						busy     <= 1'b0;
					end
					else
					begin
						cnt   <= cnt + 1'b1;
						req_q <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (mem.rvalid)
			vid_data <= mem.rdata;
	end

	// reads only, from offset zero of the screen page
	assign mem.req   = req_q;
	assign mem.addr  = {page_q, WIN_OFS_W'(cnt)};
	assign mem.rnw   = 1'b1;
	assign mem.bsel  = 2'b11;
	assign mem.wdata = '0;

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
(
	input  logic fclk,
	input  logic rst_n,

	mem_req_if.arbiter vid,
	mem_req_if.arbiter cpu,
	mem_port_if.arbiter mem
);
	import zx_mem_pkg::*;

	logic [CRED_W-1:0] credits;
	logic vid_pend;
	logic cpu_pend;
	logic issue;
	logic pick_vid;

	// a peer under grant this cycle drops req next edge
	assign vid_pend = vid.req && !vid.gnt;
	assign cpu_pend = cpu.req && !cpu.gnt;

	// nothing goes out without a credit
	assign issue = (vid_pend || cpu_pend) && (credits != '0);

	// video first
	assign pick_vid = vid_pend;

	////////////////////////////////////////
	// grant and credit count
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			credits   <= CRED_W'(MEM_CREDITS);
			vid.gnt   <= 1'b0;
			cpu.gnt   <= 1'b0;
			mem.valid <= 1'b0;
		end
		else
		begin
			credits   <= credits - CRED_W'(issue) + CRED_W'(mem.credit);
			vid.gnt   <= issue && pick_vid;
			cpu.gnt   <= issue && !pick_vid;
			mem.valid <= issue;
		end
	end

	// request payload to the store
	always_ff @(posedge fclk)
	begin
		if (issue)
		begin
			if (pick_vid)
			begin
				mem.addr  <= vid.addr;
				mem.rnw   <= vid.rnw;
				mem.bsel  <= vid.bsel;
				mem.wdata <= vid.wdata;
				mem.tag   <= TAG_VID;
			end
			else
			begin
				mem.addr  <= cpu.addr;
				mem.rnw   <= cpu.rnw;
				mem.bsel  <= cpu.bsel;
				mem.wdata <= cpu.wdata;
				mem.tag   <= TAG_CPU;
			end
		end
	end

	////////////////////////////////////////
	// response steering
	////////////////////////////////////////

	assign vid.rvalid = mem.rvalid && (mem.rtag == TAG_VID);
	assign cpu.rvalid = mem.rvalid && (mem.rtag == TAG_CPU);

	assign vid.rdata = mem.rdata;
	assign cpu.rdata = mem.rdata;

endmodule

// ==== src/mem_store.sv ====
`timescale 1ns/1ps

module mem_store
(
	input  logic fclk,
	input  logic rst_n,

	mem_port_if.store mem
);
	import zx_mem_pkg::*;

	word_t mem_arr [2**MEM_AW];

	logic [MEM_AW-1:0] idx;
	logic [MEM_LAT-1:0] vld_q;
	logic [MEM_LAT-1:0] rnw_q;
	tag_t tag_q [MEM_LAT];
	word_t data_q [MEM_LAT];

	// upper address bits alias
	assign idx = mem.addr[MEM_AW-1:0];

	////////////////////////////////////////
	// word array with byte enables
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (mem.valid && !mem.rnw)
		begin
			if (mem.bsel[0])
				mem_arr[idx][7:0] <= mem.wdata[7:0];
			if (mem.bsel[1])
				mem_arr[idx][15:8] <= mem.wdata[15:8];
		end
	end

	////////////////////////////////////////
	// fixed latency pipeline
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			vld_q <= '0;
		else
			vld_q <= {vld_q[MEM_LAT-2:0], mem.valid};
	end

	// stage 0 reads the array, later stages just shift
	always_ff @(posedge fclk)
	begin
		rnw_q     <= {rnw_q[MEM_LAT-2:0], mem.rnw};
		tag_q[0]  <= mem.tag;
		data_q[0] <= mem_arr[idx];
		for (int i = 1; i < MEM_LAT; i++)
		begin
			tag_q[i]  <= tag_q[i-1];
			data_q[i] <= data_q[i-1];
		end
	end

	// every request retires at the exit and hands its credit back
	assign mem.credit = vld_q[MEM_LAT-1];
	assign mem.rvalid = vld_q[MEM_LAT-1] && rnw_q[MEM_LAT-1];
	assign mem.rdata  = data_q[MEM_LAT-1];
	assign mem.rtag   = tag_q[MEM_LAT-1];

endmodule

// ==== src/zx_mem_top.sv ====
`timescale 1ns/1ps

module zx_mem_top
(
	input  logic fclk,
	input  logic rst_n,

	// z80 access
	input  logic cpu_req,
	input  logic cpu_rnw,
	input  logic [zx_mem_pkg::ZA_W-1:0] cpu_a,
	input  logic [zx_mem_pkg::ZD_W-1:0] cpu_dout,
	output logic [zx_mem_pkg::ZD_W-1:0] cpu_din,
	output logic cpu_busy,
	output logic cpu_done,

	// page registers
	input  logic page_wr,
	input  logic [1:0] page_win,
	input  logic [zx_mem_pkg::PAGE_W-1:0] page_val,
	input  logic page_prot,

	// screen
	input  logic frame_start,
	input  logic scr_sel,
	output logic [zx_mem_pkg::WD_W-1:0] vid_data,
	output logic vid_strobe,
	output logic vid_last
);
	import zx_mem_pkg::*;

	logic [ZA_W-1:0] pg_a;
	waddr_t pg_waddr;
	logic [1:0] pg_bsel;
	logic pg_prot;

	mem_req_if vid_bus();
	mem_req_if cpu_bus();
	mem_port_if mem_bus();

	window_pager pager
	(
		.fclk(fclk), .rst_n(rst_n),
		.page_wr(page_wr), .page_win(page_win),
		.page_val(page_val), .page_prot(page_prot),
		.za(pg_a), .waddr(pg_waddr), .bsel(pg_bsel), .prot(pg_prot)
	);

	z80_mem_port z80_port
	(
		.fclk(fclk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_rnw(cpu_rnw), .cpu_a(cpu_a), .cpu_dout(cpu_dout),
		.cpu_din(cpu_din), .cpu_busy(cpu_busy), .cpu_done(cpu_done),
		.pg_a(pg_a), .waddr(pg_waddr), .bsel(pg_bsel), .prot(pg_prot),
		.mem(cpu_bus)
	);

	screen_fetch fetcher
	(
		.fclk(fclk), .rst_n(rst_n),
		.frame_start(frame_start), .scr_sel(scr_sel),
		.vid_data(vid_data), .vid_strobe(vid_strobe), .vid_last(vid_last),
		.mem(vid_bus)
	);

	mem_arbiter arb
	(
		.fclk(fclk), .rst_n(rst_n),
		.vid(vid_bus), .cpu(cpu_bus), .mem(mem_bus)
	);

	mem_store store
	(
		.fclk(fclk), .rst_n(rst_n),
		.mem(mem_bus)
	);

endmodule

// ==== testbench/tb_zx_mem.sv ====
`timescale 1ns/1ps

module tb_zx_mem;
	import zx_mem_pkg::*;

	localparam int INIT_BYTES = 64;
	localparam int ROUNDS = 6;
	localparam int ROUND_OPS = 24;
	localparam int PROT_ROUNDS = 3;
	localparam int PROT_OPS = 4;
	localparam int CONT_OPS = 20;
	// worst case cycles for one access, page write or burst word
	localparam int ACC_CYC = 16;
	localparam int N_STEPS = 8 * (INIT_BYTES + 1) + 4 + ROUNDS * (WIN_N + ROUND_OPS)
		+ PROT_ROUNDS * (2 + 2 * PROT_OPS) + 2 * CONT_OPS + 4 * (VID_WORDS + 2);
	localparam int CYCLE_LIMIT = N_STEPS * ACC_CYC;

	logic fclk;
	logic rst_n;
	logic cpu_req, cpu_rnw;
	logic [15:0] cpu_a;
	logic [7:0] cpu_dout;
	logic [7:0] cpu_din;
	logic cpu_busy, cpu_done;
	logic page_wr, page_prot;
	logic [1:0] page_win;
	logic [7:0] page_val;
	logic frame_start, scr_sel;
	logic [15:0] vid_data;
	logic vid_strobe, vid_last;

	// byte image of the store and page registers as the reference model
	logic [7:0] model_mem [2**(MEM_AW+1)];
	page_t model_page [WIN_N];
	logic [WIN_N-1:0] model_prot;
	logic [31:0] rng;
	int errors = 0;
	int reads = 0;
	int words = 0;
	int cycles = 0;

	zx_mem_top UUT
	(
		.fclk(fclk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_rnw(cpu_rnw), .cpu_a(cpu_a), .cpu_dout(cpu_dout),
		.cpu_din(cpu_din), .cpu_busy(cpu_busy), .cpu_done(cpu_done),
		.page_wr(page_wr), .page_win(page_win), .page_val(page_val), .page_prot(page_prot),
		.frame_start(frame_start), .scr_sel(scr_sel),
		.vid_data(vid_data), .vid_strobe(vid_strobe), .vid_last(vid_last)
	);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	always @(posedge fclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: no DUT handshake within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// model helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// window from a[15:14], page above word offset a[13:1], byte lane a[0]
	function automatic logic [MEM_AW:0] byte_addr(input logic [15:0] a);
		logic [WA_W-1:0] wa;
		wa = {model_page[a[15:14]], a[13:1]};
		return {wa[MEM_AW-1:0], a[0]};
	endfunction

	function automatic word_t model_word(input page_t pg, input int n);
		logic [WA_W-1:0] wa;
		wa = {pg, WIN_OFS_W'(n)};
		return {model_mem[{wa[MEM_AW-1:0], 1'b1}], model_mem[{wa[MEM_AW-1:0], 1'b0}]};
	endfunction

	function automatic logic [7:0] fill_byte(input logic [MEM_AW:0] ba);
		return ba[7:0] ^ 8'(ba[16:9] * 8'd29) ^ ba[15:8];
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("FAIL %s: expected 0x%0h, actual 0x%0h", test, exp, act);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error: %s", msg);
	endtask

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////

	task automatic set_page(input logic [1:0] win, input page_t pg, input logic pr);
		@(negedge fclk);
		page_wr = 1'b1;
		page_win = win;
		page_val = pg;
		page_prot = pr;
		@(negedge fclk);
		page_wr = 1'b0;
		model_page[win] = pg;
		model_prot[win] = pr;
	endtask

	task automatic cpu_access(input logic rnw, input logic [15:0] a, input logic [7:0] d,
		output logic [7:0] din);
		@(negedge fclk);
		cpu_req = 1'b1;
		cpu_rnw = rnw;
		cpu_a = a;
		cpu_dout = d;
		@(negedge fclk);
		cpu_req = 1'b0;
		if (cpu_busy !== 1'b1)
			report_error("cpu_busy did not rise after cpu_req");
		while (!cpu_done)
			@(negedge fclk);
		din = cpu_din;
		@(negedge fclk);
	endtask

	task automatic mem_access(input string test, input logic rnw, input logic [15:0] a,
		input logic [7:0] d);
		logic [MEM_AW:0] ba;
		logic [7:0] din;
		ba = byte_addr(a);
		cpu_access(rnw, a, d, din);
		if (rnw)
		begin
			reads++;
			if (din !== model_mem[ba])
				report_mismatch(test, model_mem[ba], din);
		end
		else if (!model_prot[a[15:14]])
			model_mem[ba] = d;
	endtask

	task automatic random_access(input string test, input logic guard, input page_t guard_pg);
		logic [31:0] r;
		logic [15:0] a;
		logic [MEM_AW:0] ba;
		logic rnw;
		r = next_rand();
		a = {r[15:14], 8'h00, r[5:0]};
		rnw = r[16];
		ba = byte_addr(a);
		// keep writes off the page a burst is reading
		if (guard && ba[MEM_AW:MEM_AW-2] == guard_pg[2:0])
			rnw = 1'b1;
		mem_access(test, rnw, a, r[31:24]);
	endtask

	task automatic run_burst(input string test, input logic sel);
		page_t pg;
		word_t exp;
		int n;
		logic seen_last;
		pg = sel ? SCR_PAGE1 : SCR_PAGE0;
		n = 0;
		seen_last = 1'b0;
		@(negedge fclk);
		scr_sel = sel;
		frame_start = 1'b1;
		@(negedge fclk);
		frame_start = 1'b0;
		while (!seen_last)
		begin
			@(negedge fclk);
			if (vid_strobe)
			begin
				exp = model_word(pg, n);
				if (vid_data !== exp)
					report_mismatch(test, exp, vid_data);
				if (vid_last !== (n == VID_WORDS - 1))
					report_mismatch({test, " vid_last"}, n == VID_WORDS - 1, vid_last);
				words++;
				n++;
				seen_last = vid_last || n >= VID_WORDS;
			end
			else if (vid_last)
				report_error("vid_last without vid_strobe");
		end
		// bus should stay quiet once the burst is over
		repeat (2 * MEM_LAT + 4)
		begin
			@(negedge fclk);
			if (vid_strobe)
				report_error("vid_strobe after the last word of a burst");
		end
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		logic [15:0] a;
		logic [1:0] win;
		cpu_req = 1'b0;
		cpu_rnw = 1'b1;
		cpu_a = '0;
		cpu_dout = '0;
		page_wr = 1'b0;
		page_win = '0;
		page_val = '0;
		page_prot = 1'b0;
		frame_start = 1'b0;
		scr_sel = 1'b0;
		rst_n = 1'b0;
		rng = 32'hfee7;
		// window i on page i and window 0 write protected
		for (int i = 0; i < WIN_N; i++)
			model_page[i] = page_t'(i);
		model_prot = 4'b0001;
		repeat (2) @(posedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);
		if ({cpu_busy, cpu_done, vid_strobe, vid_last} !== 4'b0000)
			report_mismatch("reset outputs", 0, {cpu_busy, cpu_done, vid_strobe, vid_last});

		// preload the low bytes of every page through window 3
		for (int p = 0; p < 8; p++)
		begin
			set_page(2'd3, page_t'(p), 1'b0);
			for (int b = 0; b < INIT_BYTES; b++)
			begin
				a = {2'b11, 8'h00, 6'(b)};
				mem_access("preload", 1'b0, a, fill_byte(byte_addr(a)));
			end
		end

		// window 0 still holds its reset protection
		r = next_rand();
		a = {2'b00, 8'h00, r[5:0]};
		mem_access("reset rom write", 1'b0, a, ~model_mem[byte_addr(a)]);
		mem_access("reset rom read", 1'b1, a, 8'h00);
		// windows 1 and 2 still sit on their reset pages
		a = {2'b01, 8'h00, r[13:8]};
		mem_access("reset page read", 1'b1, a, 8'h00);
		a = {2'b10, 8'h00, r[21:16]};
		mem_access("reset page read", 1'b1, a, 8'h00);

		for (int k = 0; k < ROUNDS; k++)
		begin
			for (int w = 0; w < WIN_N; w++)
			begin
				r = next_rand();
				set_page(2'(w), page_t'(r[2:0]), 1'b0);
			end
			repeat (ROUND_OPS) random_access("paging", 1'b0, 8'd0);
		end

		for (int k = 0; k < PROT_ROUNDS; k++)
		begin
			r = next_rand();
			win = r[1:0];
			set_page(win, page_t'(r[10:8]), 1'b1);
			for (int j = 0; j < PROT_OPS; j++)
			begin
				r = next_rand();
				a = {win, 8'h00, r[5:0]};
				mem_access("protect write", 1'b0, a, ~model_mem[byte_addr(a)]);
				mem_access("protect read", 1'b1, a, 8'h00);
			end
			set_page(win, model_page[win], 1'b0);
		end

		run_burst("burst page0", 1'b0);
		run_burst("burst page1", 1'b1);

		// cpu traffic against a running burst
		for (int k = 0; k < 2; k++)
		begin
			fork
				run_burst("contention burst", k[0]);
				repeat (CONT_OPS)
					random_access("contention", 1'b1, k[0] ? SCR_PAGE1 : SCR_PAGE0);
			join
		end

		repeat (4) @(negedge fclk);
		$display("reads checked %0d, screen words %0d, errors %0d", reads, words, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== vlog.f ====
src/zx_mem_pkg.sv
src/mem_req_if.sv
src/mem_port_if.sv
src/window_pager.sv
src/z80_mem_port.sv
src/screen_fetch.sv
src/mem_arbiter.sv
src/mem_store.sv
src/zx_mem_top.sv
testbench/tb_zx_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_zx_mem -f vlog.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^No errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
